/* build.f */
rot_cfg_pkg.sv
rot_img_pkg.sv
rot_regs.sv
rot_frame_writer.sv
rot_frame_reader.sv
rot_sram_arbiter.sv
rot_sram.sv
rotate_top.sv
rotate_sva.sv
rotate_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rotate_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run counts as passed only when the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rotate_tb.sv */
`timescale 1ns/1ps

module rotate_tb;

   typedef struct packed {
      logic                                       enable;
      logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] sin_theta;
      logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] cos_theta;
      logic                                       back_to_back;
      logic [1:0]                                 out_frames;
   } row_s;

   localparam int NROWS          = 6;
   localparam int TIMEOUT_CYCLES = NROWS * 1200 + 500;

   // Enable, sine, cosine, second frame sent at once, rotated frames expected
   localparam row_s ROWS [NROWS] = '{
      '{1'b0, 10'sd0,    10'sd256, 1'b0, 2'd0},
      '{1'b1, 10'sd0,    10'sd256, 1'b0, 2'd1},
      '{1'b1, 10'sd256,  10'sd0,   1'b0, 2'd1},
      '{1'b1, 10'sd181,  10'sd181, 1'b0, 2'd1},
      '{1'b1, -10'sd181, 10'sd181, 1'b1, 2'd2},
      '{1'b0, 10'sd181,  10'sd181, 1'b0, 2'd0}
   };

   logic                     clk = 1'b0;
   logic                     arst_n;
   logic [15:0]              di_term_addr;
   logic [31:0]              di_reg_addr;
   logic                     di_write;
   logic [31:0]              di_reg_datai;
   logic [31:0]              di_reg_datao;
   logic                     di_read_rdy;
   logic                     di_write_rdy;
   logic [15:0]              di_transfer_status;
   logic                     di_en;
   rot_img_pkg::pix_stream_s stream_in;
   rot_img_pkg::pix_stream_s stream_out;

   rot_img_pkg::pix_stream_s prev_in = '0;
   logic                     check_bypass = 1'b0;
   logic                     collect = 1'b0;
   logic [15:0]              sent [512];
   logic [15:0]              got [512];
   int                       frames_seen = 0;
   int                       out_idx = 0;
   int                       cycles = 0;
   int                       pix_errors = 0;
   int                       bypass_errors = 0;
   int                       reg_errors = 0;
   int                       frame_errors = 0;
   integer                   seed = 32'h7112;

   rotate_top rotate_top_i (
      .clk                (clk),
      .arst_n             (arst_n),
      .di_term_addr       (di_term_addr),
      .di_reg_addr        (di_reg_addr),
      .di_write           (di_write),
      .di_reg_datai       (di_reg_datai),
      .di_reg_datao       (di_reg_datao),
      .di_read_rdy        (di_read_rdy),
      .di_write_rdy       (di_write_rdy),
      .di_transfer_status (di_transfer_status),
      .di_en              (di_en),
      .stream_in          (stream_in),
      .stream_out         (stream_out)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Gathers rotated frames, two slots are enough for back to back frames
   always @(negedge clk) begin
      if (collect && stream_out.dv) begin
         case (stream_out.dtype)
            rot_img_pkg::DT_FRAME_START: begin
               out_idx = 0;
            end
            rot_img_pkg::DT_PIXEL: begin
               if (out_idx < rot_img_pkg::FRAME_PIXELS) begin
                  got[9'((frames_seen % 2) * rot_img_pkg::FRAME_PIXELS + out_idx)] =
                     stream_out.data;
               end
               out_idx = out_idx + 1;
            end
            rot_img_pkg::DT_FRAME_END: begin
               assert (out_idx == rot_img_pkg::FRAME_PIXELS) else begin
                  frame_errors++;
                  $display("** Error at %0t: output frame %0d has %0d pixels, expected %0d",
                           $time, frames_seen, out_idx, rot_img_pkg::FRAME_PIXELS);
               end
               frames_seen = frames_seen + 1;
            end
            default: begin
               out_idx = out_idx;
            end
         endcase
      end
   end

   // Nearest source pixel for output position x,y, zero outside the frame
   function automatic logic [15:0] model_pixel(input int k, input int x, input int y,
                                               input int s, input int c);
      int dx;
      int dy;
      int src_x;
      int src_y;
      dx    = x - rot_img_pkg::CENTER;
      dy    = y - rot_img_pkg::CENTER;
      src_x = rot_img_pkg::CENTER + ((dx * c + dy * s) >>> rot_cfg_pkg::ANGLE_FRAC);
      src_y = rot_img_pkg::CENTER + ((dy * c - dx * s) >>> rot_cfg_pkg::ANGLE_FRAC);
      if (src_x < 0 || src_x >= rot_img_pkg::FRAME_DIM ||
          src_y < 0 || src_y >= rot_img_pkg::FRAME_DIM) begin
         return 16'h0000;
      end
      return sent[9'(k * rot_img_pkg::FRAME_PIXELS + src_y * rot_img_pkg::FRAME_DIM + src_x)];
   endfunction

   task automatic drive_word(input rot_img_pkg::pix_stream_s w);
      @(negedge clk);
      if (check_bypass) begin
         assert (stream_out == prev_in) else begin
            bypass_errors++;
            $display("** Error at %0t: bypass word %h, expected %h", $time, stream_out, prev_in);
         end
      end
      stream_in = w;
      prev_in   = w;
   endtask

   task automatic send_frame(input int k);
      rot_img_pkg::pix_stream_s w;
      int                       i;
      w       = '0;
      w.dv    = 1'b1;
      w.dtype = rot_img_pkg::DT_FRAME_START;
      drive_word(w);
      for (i = 0; i < rot_img_pkg::FRAME_PIXELS; i++) begin
         if (($random(seed) & 7) == 0) begin
            drive_word('0);
         end
         sent[9'(k * rot_img_pkg::FRAME_PIXELS + i)] = 16'($random(seed));
         w.dtype = rot_img_pkg::DT_PIXEL;
         w.data  = sent[9'(k * rot_img_pkg::FRAME_PIXELS + i)];
         drive_word(w);
      end
      w.dtype = rot_img_pkg::DT_FRAME_END;
      w.data  = '0;
      drive_word(w);
   endtask

   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      @(negedge clk);
      di_term_addr = rot_cfg_pkg::TERM_ROTATE;
      di_reg_addr  = addr;
      di_reg_datai = data;
      di_write     = 1'b1;
      @(negedge clk);
      di_write = 1'b0;
   endtask

   task automatic reg_read(input logic [15:0] term, input logic [31:0] addr,
                           output logic [31:0] data, output logic [15:0] status);
      @(negedge clk);
      di_term_addr = term;
      di_reg_addr  = addr;
      di_write     = 1'b0;
      @(negedge clk);
      data   = di_reg_datao;
      status = di_transfer_status;
   endtask

   task automatic check_reg(input logic [31:0] addr, input logic [31:0] expected);
      logic [31:0] data;
      logic [15:0] status;
      reg_read(rot_cfg_pkg::TERM_ROTATE, addr, data, status);
      assert (data == expected && status == 16'd0) else begin
         reg_errors++;
         $display("** Error at %0t: register %0d read %h with status %0d, expected %h",
                  $time, addr, data, status, expected);
      end
   endtask

   task automatic check_frames(input int base, input int nf, input int s, input int c);
      int          k;
      int          p;
      logic [15:0] expected;
      logic [15:0] actual;
      for (k = 0; k < nf; k++) begin
         for (p = 0; p < rot_img_pkg::FRAME_PIXELS; p++) begin
            expected = model_pixel(k, p % rot_img_pkg::FRAME_DIM, p / rot_img_pkg::FRAME_DIM,
                                   s, c);
            actual   = got[9'(((base + k) % 2) * rot_img_pkg::FRAME_PIXELS + p)];
            assert (actual == expected) else begin
               pix_errors++;
               $display("** Error at %0t: frame %0d pixel %0d is %h, expected %h",
                        $time, k, p, actual, expected);
            end
         end
      end
   endtask

   initial begin
      rot_cfg_pkg::rot_reg_word_u word;
      row_s                       row;
      logic [31:0]                data;
      logic [15:0]                status;
      int                         r;
      int                         k;
      int                         base;
      int                         n_in;
      int                         n_out;
      int                         exp_total;
      arst_n       = 1'b0;
      di_term_addr = '0;
      di_reg_addr  = '0;
      di_write     = 1'b0;
      di_reg_datai = '0;
      stream_in    = '0;
      exp_total    = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      word                 = '0;
      word.angle.cos_theta = rot_cfg_pkg::ANGLE_ONE;
      check_reg(rot_cfg_pkg::REG_CTRL, 32'd0);
      check_reg(rot_cfg_pkg::REG_ANGLE, word);

      for (r = 0; r < NROWS; r++) begin
         row                  = ROWS[r];
         word                 = '0;
         word.angle.sin_theta = row.sin_theta;
         word.angle.cos_theta = row.cos_theta;
         reg_write(rot_cfg_pkg::REG_ANGLE, word);
         check_reg(rot_cfg_pkg::REG_ANGLE, word);
         word             = '0;
         word.ctrl.enable = row.enable;
         reg_write(rot_cfg_pkg::REG_CTRL, word);
         check_reg(rot_cfg_pkg::REG_CTRL, word);
         n_in  = row.back_to_back ? 2 : 1;
         n_out = int'(row.out_frames);

         @(posedge clk);
         collect      = row.enable;
         base         = frames_seen;
         check_bypass = !row.enable;
         for (k = 0; k < n_in; k++) begin
            send_frame(k);
         end
         drive_word('0);
         drive_word('0);
         check_bypass = 1'b0;

         // The frame end words on the output mark the rotated frames as done
         while (frames_seen < base + n_out) begin
            @(posedge clk);
         end
         @(posedge clk);
         collect = 1'b0;
         check_frames(base, n_out, int'(row.sin_theta), int'(row.cos_theta));
         exp_total = exp_total + n_out;
         check_reg(rot_cfg_pkg::REG_STATUS, 32'(exp_total));
      end

      reg_read(16'h0041, rot_cfg_pkg::REG_ANGLE, data, status);
      assert (status == 16'd1 && data == 32'd0 && !di_en && di_read_rdy && di_write_rdy) else begin
         reg_errors++;
         $display("** Error at %0t: foreign terminal gave data %h status %0d di_en %b",
                  $time, data, status, di_en);
      end

      $display("Errors: pixel %0d, bypass %0d, register %0d, framing %0d",
               pix_errors, bypass_errors, reg_errors, frame_errors);
      if (pix_errors + bypass_errors + reg_errors + frame_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* rotate_sva.sv */
`timescale 1ns/1ps

module rotate_sva (
   input logic                     clk,
   input logic                     arst_n,
   input rot_img_pkg::pix_stream_s stream_in,
   input rot_img_pkg::sram_req_s   mem_req,
   input logic                     rd_grant,
   input logic                     rdata_valid,
   input rot_img_pkg::pix_stream_s rot_out,
   input rot_img_pkg::pix_stream_s stream_out
);

   logic in_frame;
   logic start_word;
   logic end_word;
   logic in_pixel;
   logic rot_pixel;

   assign start_word = stream_out.dv && (stream_out.dtype == rot_img_pkg::DT_FRAME_START);
   assign end_word   = stream_out.dv && (stream_out.dtype == rot_img_pkg::DT_FRAME_END);
   assign in_pixel   = stream_in.dv && (stream_in.dtype == rot_img_pkg::DT_PIXEL);
   assign rot_pixel  = rot_out.dv && (rot_out.dtype == rot_img_pkg::DT_PIXEL);

   // Set between a frame start and its frame end on the output
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         in_frame <= 1'b0;
      end else if (start_word) begin
         in_frame <= 1'b1;
      end else if (end_word) begin
         in_frame <= 1'b0;
      end
   end

   // An incoming pixel always owns the memory port as a write
   writer_first: assert property (@(posedge clk) disable iff (!arst_n)
      in_pixel |-> (mem_req.req && mem_req.we && !rd_grant))
      else $error("Reader granted while the writer requests the SRAM");

   data_after_grant: assert property (@(posedge clk) disable iff (!arst_n)
      rd_grant |=> rdata_valid ##1 rot_pixel)
      else $error("Read data from a reader grant did not reach the output stream");

   single_start: assert property (@(posedge clk) disable iff (!arst_n)
      start_word |-> !in_frame)
      else $error("Second frame start on the output without a frame end");

   end_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
      end_word |-> in_frame)
      else $error("Frame end on the output without a frame start");

endmodule

bind rotate_top rotate_sva rotate_sva_i (
   .clk         (clk),
   .arst_n      (arst_n),
   .stream_in   (stream_in),
   .mem_req     (mem_req),
   .rd_grant    (rd_grant),
   .rdata_valid (rdata_valid),
   .rot_out     (rot_out),
   .stream_out  (stream_out)
);

/* rotate_top.sv */
`timescale 1ns/1ps

module rotate_top (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [15:0]              di_term_addr,
   input  logic [31:0]              di_reg_addr,
   input  logic                     di_write,
   input  logic [31:0]              di_reg_datai,
   output logic [31:0]              di_reg_datao,
   output logic                     di_read_rdy,
   output logic                     di_write_rdy,
   output logic [15:0]              di_transfer_status,
   output logic                     di_en,
   input  rot_img_pkg::pix_stream_s stream_in,
   output rot_img_pkg::pix_stream_s stream_out
);

   logic                                       enable;
   logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] sin_theta;
   logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] cos_theta;
   logic                                       frame_done;
   logic                                       frame_bank;
   logic                                       frame_out_done;
   rot_img_pkg::sram_req_s                     wr_req;
   rot_img_pkg::sram_req_s                     rd_req;
   rot_img_pkg::sram_req_s                     mem_req;
   logic                                       rd_grant;
   logic [rot_img_pkg::PIX_WIDTH-1:0]          mem_rdata;
   logic [rot_img_pkg::PIX_WIDTH-1:0]          rdata;
   logic                                       rdata_valid;
   rot_img_pkg::pix_stream_s                   rot_out;
   rot_img_pkg::pix_stream_s                   bypass_q;

   rot_regs rot_regs (
      .clk                (clk),
      .arst_n             (arst_n),
      .di_term_addr       (di_term_addr),
      .di_reg_addr        (di_reg_addr),
      .di_write           (di_write),
      .di_reg_datai       (di_reg_datai),
      .frame_out_done     (frame_out_done),
      .di_reg_datao       (di_reg_datao),
      .di_read_rdy        (di_read_rdy),
      .di_write_rdy       (di_write_rdy),
      .di_transfer_status (di_transfer_status),
      .di_en              (di_en),
      .enable             (enable),
      .sin_theta          (sin_theta),
      .cos_theta          (cos_theta)
   );

   rot_frame_writer writer (
      .clk        (clk),
      .arst_n     (arst_n),
      .stream_in  (stream_in),
      .wr_req     (wr_req),
      .frame_done (frame_done),
      .frame_bank (frame_bank)
   );

   // Only frames completed while rotation is on are read back
   rot_frame_reader reader (
      .clk            (clk),
      .arst_n         (arst_n),
      .frame_done     (frame_done && enable),
      .frame_bank     (frame_bank),
      .sin_theta      (sin_theta),
      .cos_theta      (cos_theta),
      .rd_req         (rd_req),
      .rd_grant       (rd_grant),
      .rdata          (rdata),
      .rdata_valid    (rdata_valid),
      .stream_out     (rot_out),
      .frame_out_done (frame_out_done)
   );

   rot_sram_arbiter arbiter (
      .clk         (clk),
      .arst_n      (arst_n),
      .wr_req      (wr_req),
      .rd_req      (rd_req),
      .rd_grant    (rd_grant),
      .mem_req     (mem_req),
      .mem_rdata   (mem_rdata),
      .rdata       (rdata),
      .rdata_valid (rdata_valid)
   );

   rot_sram sram (
      .clk       (clk),
      .mem_req   (mem_req),
      .mem_rdata (mem_rdata)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bypass_q <= '0;
      end else begin
         bypass_q <= stream_in;
      end
   end

   assign stream_out = enable ? rot_out : bypass_q;

endmodule

/* rot_sram.sv */
`timescale 1ns/1ps

module rot_sram (
   input  logic                              clk,
   input  rot_img_pkg::sram_req_s            mem_req,
   output logic [rot_img_pkg::PIX_WIDTH-1:0] mem_rdata
);

   logic [rot_img_pkg::PIX_WIDTH-1:0] mem [2**rot_img_pkg::SRAM_ADDR_WIDTH];

   always_ff @(posedge clk) begin
      if (mem_req.req) begin
         if (mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
         end else begin
            mem_rdata <= mem[mem_req.addr];
         end
      end
   end

endmodule

/* rot_sram_arbiter.sv */
`timescale 1ns/1ps

module rot_sram_arbiter (
   input  logic                              clk,
   input  logic                              arst_n,
   input  rot_img_pkg::sram_req_s            wr_req,
   input  rot_img_pkg::sram_req_s            rd_req,
   output logic                              rd_grant,
   output rot_img_pkg::sram_req_s            mem_req,
   input  logic [rot_img_pkg::PIX_WIDTH-1:0] mem_rdata,
   output logic [rot_img_pkg::PIX_WIDTH-1:0] rdata,
   output logic                              rdata_valid
);

   // Incoming pixels cannot wait, so the writer has the port whenever it asks
   assign rd_grant = rd_req.req && !wr_req.req;
   assign mem_req  = wr_req.req ? wr_req : rd_req;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata_valid <= 1'b0;
      end else begin
         rdata_valid <= rd_grant;
      end
   end

   assign rdata = mem_rdata;

endmodule

/* rot_frame_reader.sv */
`timescale 1ns/1ps

module rot_frame_reader (
   input  logic                                       clk,
   input  logic                                       arst_n,
   input  logic                                       frame_done,
   input  logic                                       frame_bank,
   input  logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] sin_theta,
   input  logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] cos_theta,
   output rot_img_pkg::sram_req_s                     rd_req,
   input  logic                                       rd_grant,
   input  logic [rot_img_pkg::PIX_WIDTH-1:0]          rdata,
   input  logic                                       rdata_valid,
   output rot_img_pkg::pix_stream_s                   stream_out,
   output logic                                       frame_out_done
);

   typedef enum logic [1:0] {S_IDLE, S_START, S_RUN, S_END} state_e;

   localparam logic [7:0] LAST_POS = 8'(rot_img_pkg::FRAME_PIXELS - 1);

   state_e                                    state;
   logic                                      pending;
   logic                                      pend_bank;
   logic                                      bank;
   logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] sin_r;
   logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] cos_r;
   logic [7:0]                                pos;
   logic                                      slot_valid;
   logic signed [4:0]                         dx;
   logic signed [4:0]                         dy;
   logic signed [15:0]                        col_sum;
   logic signed [15:0]                        row_sum;
   logic signed [15:0]                        src_col;
   logic signed [15:0]                        src_row;
   logic                                      in_range;
   logic                                      take;
   logic                                      start_now;

   // Output position relative to the frame centre
   assign dx = 5'($signed({1'b0, pos[3:0]}) - rot_img_pkg::CENTER);
   assign dy = 5'($signed({1'b0, pos[7:4]}) - rot_img_pkg::CENTER);

   assign col_sum = dx * cos_r + dy * sin_r;
   assign row_sum = dy * cos_r - dx * sin_r;
   assign src_col = (col_sum >>> rot_cfg_pkg::ANGLE_FRAC) + 16'(rot_img_pkg::CENTER);
   assign src_row = (row_sum >>> rot_cfg_pkg::ANGLE_FRAC) + 16'(rot_img_pkg::CENTER);

   assign in_range = (src_col >= 0) && (src_col < rot_img_pkg::FRAME_DIM) &&
                     (src_row >= 0) && (src_row < rot_img_pkg::FRAME_DIM);

   assign start_now = (state == S_IDLE) && (pending || frame_done);

   // A position moves on at once when it falls outside the frame
   assign take = (state == S_RUN) && (!in_range || rd_grant);

   always_comb begin
      rd_req.req   = (state == S_RUN) && in_range;
      rd_req.we    = 1'b0;
      rd_req.addr  = {bank, src_row[3:0], src_col[3:0]};
      rd_req.wdata = '0;
   end

   always_ff @(posedge clk) begin
      if (start_now) begin
         bank  <= pending ? pend_bank : frame_bank;
         sin_r <= sin_theta;
         cos_r <= cos_theta;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= S_IDLE;
         pending    <= 1'b0;
         pend_bank  <= 1'b0;
         pos        <= '0;
         slot_valid <= 1'b0;
      end else begin
         slot_valid <= take;
         if (frame_done && (state != S_IDLE || pending)) begin
            pending   <= 1'b1;
            pend_bank <= frame_bank;
         end else if (start_now) begin
            pending <= 1'b0;
         end
         case (state)
            S_IDLE: begin
               if (start_now) begin
                  state <= S_START;
               end
            end
            S_START: begin
               state <= S_RUN;
               pos   <= '0;
            end
            S_RUN: begin
               if (take) begin
                  pos <= pos + 1'b1;
                  if (pos == LAST_POS) begin
                     state <= S_END;
                  end
               end
            end
            default: begin
               if (!slot_valid) begin
                  state <= S_IDLE;
               end
            end
         endcase
      end
   end

   // The slot holds the position taken last cycle, its read data arrives now
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stream_out     <= '0;
         frame_out_done <= 1'b0;
      end else begin
         stream_out     <= '0;
         frame_out_done <= 1'b0;
         if (slot_valid) begin
            stream_out.dv    <= 1'b1;
            stream_out.dtype <= rot_img_pkg::DT_PIXEL;
            stream_out.data  <= rdata_valid ? rdata : '0;
         end else if (state == S_START) begin
            stream_out.dv    <= 1'b1;
            stream_out.dtype <= rot_img_pkg::DT_FRAME_START;
         end else if (state == S_END) begin
            stream_out.dv    <= 1'b1;
            stream_out.dtype <= rot_img_pkg::DT_FRAME_END;
            frame_out_done   <= 1'b1;
         end
      end
   end

endmodule

/* rot_frame_writer.sv */
`timescale 1ns/1ps

module rot_frame_writer (
   input  logic                     clk,
   input  logic                     arst_n,
   input  rot_img_pkg::pix_stream_s stream_in,
   output rot_img_pkg::sram_req_s   wr_req,
   output logic                     frame_done,
   output logic                     frame_bank
);

   logic [rot_img_pkg::SRAM_ADDR_WIDTH-2:0] pix_cnt;
   logic                                    bank;
   logic                                    is_pixel;

   assign is_pixel = stream_in.dv && (stream_in.dtype == rot_img_pkg::DT_PIXEL);

   // Pixels go straight to the memory port, the writer always wins arbitration
   always_comb begin
      wr_req.req   = is_pixel;
      wr_req.we    = 1'b1;
      wr_req.addr  = {bank, pix_cnt};
      wr_req.wdata = stream_in.data;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pix_cnt    <= '0;
         bank       <= 1'b0;
         frame_done <= 1'b0;
         frame_bank <= 1'b0;
      end else begin
         frame_done <= 1'b0;
         if (stream_in.dv) begin
            case (stream_in.dtype)
               rot_img_pkg::DT_FRAME_START: begin
                  pix_cnt <= '0;
               end
               rot_img_pkg::DT_PIXEL: begin
                  pix_cnt <= pix_cnt + 1'b1;
               end
               rot_img_pkg::DT_FRAME_END: begin
                  frame_done <= 1'b1;
                  frame_bank <= bank;
                  bank       <= !bank;
               end
               default: begin
                  pix_cnt <= pix_cnt;
               end
            endcase
         end
      end
   end

endmodule

/* rot_regs.sv */
`timescale 1ns/1ps

module rot_regs (
   input  logic                                    clk,
   input  logic                                    arst_n,
   input  logic [15:0]                             di_term_addr,
   input  logic [31:0]                             di_reg_addr,
   input  logic                                    di_write,
   input  logic [31:0]                             di_reg_datai,
   input  logic                                    frame_out_done,
   output logic [31:0]                             di_reg_datao,
   output logic                                    di_read_rdy,
   output logic                                    di_write_rdy,
   output logic [15:0]                             di_transfer_status,
   output logic                                    di_en,
   output logic                                    enable,
   output logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] sin_theta,
   output logic signed [rot_cfg_pkg::ANGLE_WIDTH-1:0] cos_theta
);

   rot_cfg_pkg::rot_reg_word_u wr_word;
   rot_cfg_pkg::rot_reg_word_u rd_word;
   logic                       term_hit;
   logic [31:0]                frame_count;

   assign term_hit = (di_term_addr == rot_cfg_pkg::TERM_ROTATE);
   assign wr_word  = di_reg_datai;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         enable    <= 1'b0;
         sin_theta <= '0;
         cos_theta <= rot_cfg_pkg::ANGLE_ONE;
      end else if (di_write && term_hit) begin
         if (di_reg_addr == rot_cfg_pkg::REG_CTRL) begin
            enable <= wr_word.ctrl.enable;
         end else if (di_reg_addr == rot_cfg_pkg::REG_ANGLE) begin
            sin_theta <= wr_word.angle.sin_theta;
            cos_theta <= wr_word.angle.cos_theta;
         end
      end
   end

   // Counts rotated frames that have left the block
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         frame_count <= '0;
      end else if (frame_out_done) begin
         frame_count <= frame_count + 32'd1;
      end
   end

   always_comb begin
      rd_word = '0;
      case (di_reg_addr)
         rot_cfg_pkg::REG_CTRL: begin
            rd_word.ctrl.enable = enable;
         end
         rot_cfg_pkg::REG_ANGLE: begin
            rd_word.angle.sin_theta = sin_theta;
            rd_word.angle.cos_theta = cos_theta;
         end
         rot_cfg_pkg::REG_STATUS: begin
            rd_word = frame_count;
         end
         default: begin
            rd_word = '0;
         end
      endcase
   end

   assign di_reg_datao       = term_hit ? rd_word : 32'd0;
   assign di_read_rdy        = 1'b1;
   assign di_write_rdy       = 1'b1;
   assign di_transfer_status = {15'd0, !term_hit};
   assign di_en              = term_hit;

endmodule

/* rot_img_pkg.sv */
package rot_img_pkg;

   typedef enum logic [1:0] {
      DT_NONE        = 2'd0,
      DT_FRAME_START = 2'd1,
      DT_PIXEL       = 2'd2,
      DT_FRAME_END   = 2'd3
   } dtype_e;

   localparam int FRAME_DIM    = 16;
   localparam int FRAME_PIXELS = FRAME_DIM * FRAME_DIM;
   localparam int CENTER       = FRAME_DIM / 2;
   localparam int PIX_WIDTH    = 16;

   // Bank bit on top, then row and column of the pixel
   localparam int SRAM_ADDR_WIDTH = 9;

   typedef struct packed {
      logic                 dv;
      dtype_e               dtype;
      logic [PIX_WIDTH-1:0] data;
   } pix_stream_s;

   typedef struct packed {
      logic                       req;
      logic                       we;
      logic [SRAM_ADDR_WIDTH-1:0] addr;
      logic [PIX_WIDTH-1:0]       wdata;
   } sram_req_s;

endpackage

/* rot_cfg_pkg.sv */
package rot_cfg_pkg;

   // Terminal address of the rotate block on the di bus
   localparam logic [15:0] TERM_ROTATE = 16'h0040;

   localparam logic [31:0] REG_CTRL   = 32'd0;
   localparam logic [31:0] REG_ANGLE  = 32'd1;
   localparam logic [31:0] REG_STATUS = 32'd2;

   // Sine and cosine are signed Q1.8, so 256 stands for 1.0
   localparam int ANGLE_WIDTH = 10;
   localparam int ANGLE_FRAC  = 8;
   localparam logic signed [ANGLE_WIDTH-1:0] ANGLE_ONE = 10'sd256;

   typedef struct packed {
      logic [30:0] rsvd;
      logic        enable;
   } ctrl_view_s;

   typedef struct packed {
      logic [5:0]                    rsvd_hi;
      logic signed [ANGLE_WIDTH-1:0] cos_theta;
      logic [5:0]                    rsvd_lo;
      logic signed [ANGLE_WIDTH-1:0] sin_theta;
   } angle_view_s;

   // One register word, read either as the control view or the angle view
   typedef union packed {
      ctrl_view_s  ctrl;
      angle_view_s angle;
   } rot_reg_word_u;

endpackage
